// File: Bender.yml
package:
  name: axi_line_mem

sources:
  - mem_pkg.sv
  - sync_fifo.sv
  - line_store.sv
  - mem_wr_engine.sv
  - mem_rd_engine.sv
  - axi_line_mem.sv
  - target: test
    files:
      - axi_line_mem_checker.sv
      - axi_line_mem_tb.sv

// File: axi_line_mem.f
mem_pkg.sv
sync_fifo.sv
line_store.sv
mem_wr_engine.sv
mem_rd_engine.sv
axi_line_mem.sv
axi_line_mem_checker.sv
axi_line_mem_tb.sv

// File: axi_line_mem.sv
`timescale 1ns/1ps

// axi4 slave memory top
module axi_line_mem
	import mem_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic aw_valid,
	input aw_req_t aw,
	output logic aw_ready,
	input logic w_valid,
	input w_beat_t w,
	output logic w_ready,
	output logic b_valid,
	output b_resp_t b,
	input logic b_ready,
	input logic ar_valid,
	input ar_req_t ar,
	output logic ar_ready,
	output logic r_valid,
	output r_beat_t r,
	input logic r_ready
);

	// write engine to store
	logic st_wr_en;
	store_wr_t st_wr;
	// read engine to store and back
	logic st_rd_en;
	store_rd_t st_rd;
	logic st_rd_valid;
	logic [DATA_W-1:0] st_rd_data;

	mem_wr_engine u_wr (
		.clk(clk),
		.rst(rst),
		.aw_valid(aw_valid),
		.aw(aw),
		.aw_ready(aw_ready),
		.w_valid(w_valid),
		.w(w),
		.w_ready(w_ready),
		.b_valid(b_valid),
		.b(b),
		.b_ready(b_ready),
		.st_wr_en(st_wr_en),
		.st_wr(st_wr)
	);

	mem_rd_engine u_rd (
		.clk(clk),
		.rst(rst),
		.ar_valid(ar_valid),
		.ar(ar),
		.ar_ready(ar_ready),
		.r_valid(r_valid),
		.r(r),
		.r_ready(r_ready),
		.st_rd_en(st_rd_en),
		.st_rd(st_rd),
		.st_rd_valid(st_rd_valid),
		.st_rd_data(st_rd_data)
	);

	line_store u_store (
		.clk(clk),
		.rst(rst),
		.wr_en(st_wr_en),
		.wr(st_wr),
		.rd_en(st_rd_en),
		.rd(st_rd),
		.rd_valid(st_rd_valid),
		.rd_data(st_rd_data)
	);

endmodule

// File: axi_line_mem_checker.sv
`timescale 1ns/1ps

// axi protocol checks on the slave ports
module axi_line_mem_checker
	import mem_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic aw_valid,
	input aw_req_t aw,
	input logic aw_ready,
	input logic w_ready,
	input logic b_valid,
	input b_resp_t b,
	input logic b_ready,
	input logic ar_valid,
	input ar_req_t ar,
	input logic ar_ready,
	input logic r_valid,
	input r_beat_t r,
	input logic r_ready
);

	// failures seen so far, watched by the testbench
	int unsigned err_count = 0;

	// b held with the same id until accepted
	b_hold_a: assert property (@(posedge clk) disable iff (rst)
		b_valid && !b_ready |=> b_valid && $stable(b))
	else begin
		$error("b channel dropped or changed while stalled");
		err_count++;
	end

	// r beat held until accepted
	r_hold_a: assert property (@(posedge clk) disable iff (rst)
		r_valid && !r_ready |=> r_valid && $stable(r))
	else begin
		$error("r channel dropped or changed while stalled");
		err_count++;
	end

	// last only comes up together with a valid beat
	r_last_a: assert property (@(posedge clk) disable iff (rst)
		$rose(r.last) |-> r_valid)
	else begin
		$error("r last raised without r_valid");
		err_count++;
	end

	// bursts beyond two beats are unsupported
	aw_len_a: assert property (@(posedge clk) disable iff (rst)
		aw_valid && aw_ready |-> aw.len <= 1)
	else begin
		$error("aw burst longer than two beats");
		err_count++;
	end

	ar_len_a: assert property (@(posedge clk) disable iff (rst)
		ar_valid && ar_ready |-> ar.len <= 1)
	else begin
		$error("ar burst longer than two beats");
		err_count++;
	end

	// outputs fully defined once out of reset
	no_x_a: assert property (@(posedge clk) disable iff (rst)
		!$isunknown({aw_ready, w_ready, b_valid, b, ar_ready, r_valid, r}))
	else begin
		$error("dut output is unknown");
		err_count++;
	end

endmodule

// File: axi_line_mem_tb.sv
`timescale 1ns/1ps

module axi_line_mem_tb;
	import mem_pkg::*;

	localparam logic [31:0] SEED = 32'hf434_1e22;
	// transaction counts per test
	localparam int N_FULL = 2;
	localparam int N_MERGE_WR = 12;
	localparam int N_MERGE_RD = 10;
	localparam int N_STALL_WR = 5;
	localparam int N_BURST_RD = 6;
	localparam int NUM_TXN = N_FULL + N_MERGE_WR + N_MERGE_RD + N_STALL_WR + N_BURST_RD;

	logic clk;
	logic rst;
	logic aw_valid;
	aw_req_t aw;
	logic aw_ready;
	logic w_valid;
	w_beat_t w;
	logic w_ready;
	logic b_valid;
	b_resp_t b;
	logic b_ready;
	logic ar_valid;
	ar_req_t ar;
	logic ar_ready;
	logic r_valid;
	r_beat_t r;
	logic r_ready;

	// reference line contents
	// never written bytes stay zero
	logic [DATA_W-1:0] ref_mem [NUM_LINES][BEATS_PER_LINE];
	id_t exp_b [$];
	r_beat_t exp_r [$];
	logic b_hold;
	string cur_test;

	axi_line_mem DUT (.*);

	bind axi_line_mem axi_line_mem_checker u_chk (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("TESTS FAILED");
		$fatal(1, "%s", what);
	endtask

	task automatic expect_eq(input string test_name, input logic [299:0] expected,
			input logic [299:0] actual);
		assert (actual === expected)
		else begin
			$display("[ERROR] %s expected %0h actual %0h", test_name, expected, actual);
			$display("TESTS FAILED");
			$fatal(1, "value mismatch in %s", test_name);
		end
	endtask

	// strobed bytes replace old ones
	function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_data,
			input logic [DATA_W-1:0] new_data, input logic [STRB_W-1:0] strb);
		logic [DATA_W-1:0] res;
		res = old_data;
		for (int i = 0; i < STRB_W; i++) begin
			if (strb[i]) begin
				res[i*8 +: 8] = new_data[i*8 +: 8];
			end
		end
		return res;
	endfunction

	function automatic logic [DATA_W-1:0] random_data();
		logic [DATA_W-1:0] d;
		for (int i = 0; i < DATA_W / 32; i++) begin
			d[i*32 +: 32] = $urandom;
		end
		return d;
	endfunction

	// low six address bits are ignored by the line index
	function automatic logic [ADDR_W-1:0] line_addr(input line_idx_t line);
		return (ADDR_W'(line) << LINE_OFS) | ADDR_W'($urandom_range(63));
	endfunction

	// starts and ends on a falling edge
	task automatic write_burst(input line_idx_t line, input int len, input bit full_strb);
		id_t id;
		w_beat_t beat;
		id = id_t'($urandom);
		aw_valid = 1'b1;
		aw = '{id: id, addr: line_addr(line), len: LEN_W'(len)};
		while (!aw_ready) @(negedge clk);
		@(negedge clk);
		aw_valid = 1'b0;
		expect_eq({cur_test, " aw_ready in data phase"}, 0, aw_ready);
		exp_b.push_back(id);
		for (int i = 0; i <= len; i++) begin
			beat.data = random_data();
			beat.strb = full_strb ? '1 : STRB_W'($urandom);
			ref_mem[line][i] = merge_bytes(ref_mem[line][i], beat.data, beat.strb);
			w_valid = 1'b1;
			w = beat;
			while (!w_ready) @(negedge clk);
			@(negedge clk);
			w_valid = 1'b0;
		end
		expect_eq({cur_test, " w_ready after last beat"}, 0, w_ready);
	endtask

	// queues the expected beats without waiting for r
	task automatic read_burst(input line_idx_t line, input int len);
		r_beat_t e;
		ar_valid = 1'b1;
		ar = '{id: id_t'($urandom), addr: line_addr(line), len: LEN_W'(len)};
		for (int i = 0; i <= len; i++) begin
			e.id = ar.id;
			e.data = ref_mem[line][i];
			e.last = (i == len);
			exp_r.push_back(e);
		end
		while (!ar_ready) @(negedge clk);
		@(negedge clk);
		ar_valid = 1'b0;
	endtask

	task automatic wait_idle();
		while (exp_b.size() != 0 || exp_r.size() != 0) begin
			@(negedge clk);
		end
	endtask

	// b ready pattern and id check
	task automatic run_b_sink();
		id_t e;
		forever begin
			@(negedge clk);
			b_ready = b_hold ? 1'b0 : ($urandom_range(3) != 0);
			if (b_valid && b_ready) begin
				if (exp_b.size() == 0) begin
					report_failure("write response arrived with no write outstanding");
				end else begin
					e = exp_b.pop_front();
					expect_eq({cur_test, " b id"}, e, b.id);
				end
			end
		end
	endtask

	// random r ready gaps
	task automatic run_r_sink();
		r_beat_t e;
		forever begin
			@(negedge clk);
			r_ready = ($urandom_range(3) != 0);
			if (r_valid && r_ready) begin
				if (exp_r.size() == 0) begin
					report_failure("read beat arrived with no read outstanding");
				end else begin
					e = exp_r.pop_front();
					expect_eq({cur_test, " r beat"}, e, r);
				end
			end
		end
	endtask

	// any checker assertion failure ends the run
	always @(negedge clk) begin
		if (DUT.u_chk.err_count != 0) begin
			$display("protocol checker reported a failure");
			$display("TESTS FAILED");
			$fatal(1, "checker failure");
		end
	end

	initial begin
		#(NUM_TXN * 200);
		$display("watchdog expired before all transactions completed");
		$display("TESTS FAILED");
		$fatal(1, "timeout");
	end

	initial begin
		void'($urandom(SEED));
		rst = 1'b1;
		aw_valid = 1'b0;
		aw = '0;
		w_valid = 1'b0;
		w = '0;
		b_ready = 1'b0;
		ar_valid = 1'b0;
		ar = '0;
		r_ready = 1'b0;
		b_hold = 1'b0;
		cur_test = "reset";
		for (int l = 0; l < NUM_LINES; l++) begin
			ref_mem[l][0] = '0;
			ref_mem[l][1] = '0;
		end
		fork
			run_b_sink();
			run_r_sink();
		join_none
		repeat (2) @(negedge clk);
		rst = 1'b0;
		expect_eq("reset b_valid", 0, b_valid);
		expect_eq("reset r_valid", 0, r_valid);
		@(negedge clk);
		expect_eq("reset aw_ready", 1, aw_ready);
		expect_eq("reset ar_ready", 1, ar_ready);

		// full two beat write then read back
		cur_test = "full_burst";
		write_burst(5, 1, 1'b1);
		wait_idle();
		read_burst(5, 1);
		wait_idle();

		// strobe merge over earlier content
		// unwritten lines and beats read zero
		cur_test = "strobe_merge";
		for (int i = 0; i < N_MERGE_WR - 1; i++) begin
			write_burst(line_idx_t'($urandom_range(7)), $urandom_range(1), 1'b0);
		end
		// one beat into a fresh line leaves its second beat unwritten
		write_burst(8, 0, 1'b0);
		wait_idle();
		for (int l = 0; l < N_MERGE_RD; l++) begin
			read_burst(line_idx_t'(l), 1);
			wait_idle();
		end

		// b stalled until the id queue fills
		// ids must come back in aw order
		cur_test = "b_stall";
		b_hold = 1'b1;
		for (int i = 0; i < N_STALL_WR; i++) begin
			write_burst(line_idx_t'(16 + i), 0, 1'b1);
		end
		expect_eq("b_stall aw_ready", 0, aw_ready);
		repeat (6) @(negedge clk);
		b_hold = 1'b0;
		wait_idle();

		// back to back reads with r ready gaps
		cur_test = "read_stream";
		for (int i = 0; i < N_BURST_RD; i++) begin
			read_burst(line_idx_t'($urandom_range(20)), $urandom_range(1));
		end
		wait_idle();
		repeat (4) @(negedge clk);

		if (DUT.u_chk.err_count != 0) begin
			$display("protocol checker reported a failure");
			$display("TESTS FAILED");
			$fatal(1, "checker failure");
		end else begin
			$display("TESTS PASSED");
			$finish;
		end
	end

endmodule

// File: line_store.sv
`timescale 1ns/1ps

// array of two-beat lines with a valid bit per beat
module line_store
	import mem_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic wr_en,
	input store_wr_t wr,
	input logic rd_en,
	input store_rd_t rd,
	output logic rd_valid,
	output logic [DATA_W-1:0] rd_data
);

	logic [DATA_W-1:0] mem [NUM_LINES][BEATS_PER_LINE];
	// set on first write to a beat
	logic [NUM_LINES-1:0][BEATS_PER_LINE-1:0] beat_valid;
	logic wr_beat_valid;
	logic rd_beat_valid;

	assign wr_beat_valid = beat_valid[wr.line][wr.beat];
	assign rd_beat_valid = beat_valid[rd.line][rd.beat];

	// byte lane write
	// strobed bytes take new data
	// unstrobed bytes keep old content, or get zero on a fresh beat
	always_ff @(posedge clk) begin
		if (wr_en) begin
			for (int b = 0; b < STRB_W; b++) begin
				if (wr.strb[b]) begin
					mem[wr.line][wr.beat][b*8 +: 8] <= wr.data[b*8 +: 8];
				end else if (!wr_beat_valid) begin
					mem[wr.line][wr.beat][b*8 +: 8] <= 8'h00;
				end
			end
		end
	end

	// valid bits
	always_ff @(posedge clk) begin
		if (rst) begin
			beat_valid <= '0;
		end else if (wr_en) begin
			beat_valid[wr.line][wr.beat] <= 1'b1;
		end
	end

	// registered read, never written beat reads zero
	// a read on the same edge as a write to that beat sees the old value
	always_ff @(posedge clk) begin
		if (rd_en) begin
			rd_data <= rd_beat_valid ? mem[rd.line][rd.beat] : '0;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			rd_valid <= 1'b0;
		end else begin
			rd_valid <= rd_en;
		end
	end

endmodule

// File: mem_pkg.sv
package mem_pkg;

	// axi data path
	localparam int DATA_W = 256;
	// one strobe bit per byte lane
	localparam int STRB_W = DATA_W / 8;
	localparam int ID_W = 6;
	localparam int ADDR_W = 64;
	// axlen holds beats minus one
	localparam int LEN_W = 8;

	// line geometry
	localparam int BEATS_PER_LINE = 2;
	localparam int BEAT_W = $clog2(BEATS_PER_LINE);
	// 64 byte line
	localparam int LINE_OFS = 6;
	localparam int LINE_IDX_W = 6;
	localparam int NUM_LINES = 2 ** LINE_IDX_W;

	// queue depths
	localparam int B_FIFO_DEPTH = 4;
	localparam int AR_FIFO_DEPTH = 4;

	typedef logic [ID_W-1:0] id_t;
	typedef logic [LINE_IDX_W-1:0] line_idx_t;

	// aw channel payload
	typedef struct packed {
		id_t id;
		logic [ADDR_W-1:0] addr;
		logic [LEN_W-1:0] len;
	} aw_req_t;

	// ar channel payload, same layout as aw
	typedef struct packed {
		id_t id;
		logic [ADDR_W-1:0] addr;
		logic [LEN_W-1:0] len;
	} ar_req_t;

	// w channel payload
	typedef struct packed {
		logic [DATA_W-1:0] data;
		logic [STRB_W-1:0] strb;
	} w_beat_t;

	// r channel payload, resp and user always zero so not carried
	typedef struct packed {
		id_t id;
		logic [DATA_W-1:0] data;
		logic last;
	} r_beat_t;

	// b channel payload
	typedef struct packed {
		id_t id;
	} b_resp_t;

	// line store write command
	typedef struct packed {
		line_idx_t line;
		logic [BEAT_W-1:0] beat;
		logic [DATA_W-1:0] data;
		logic [STRB_W-1:0] strb;
	} store_wr_t;

	// line store read command
	typedef struct packed {
		line_idx_t line;
		logic [BEAT_W-1:0] beat;
	} store_rd_t;

endpackage

// File: mem_rd_engine.sv
`timescale 1ns/1ps

// ar queue and r beat sequencing
module mem_rd_engine
	import mem_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic ar_valid,
	input ar_req_t ar,
	output logic ar_ready,
	output logic r_valid,
	output r_beat_t r,
	input logic r_ready,
	output logic st_rd_en,
	output store_rd_t st_rd,
	input logic st_rd_valid,
	input logic [DATA_W-1:0] st_rd_data
);

	typedef enum logic [1:0] {
		RD_IDLE,
		RD_ISSUE,
		RD_WAIT,
		RD_HOLD
	} rd_state_e;

	rd_state_e state;
	ar_req_t arq_head;
	logic arq_pop;
	logic arq_empty;
	logic arq_full;

	// request being served
	id_t id_q;
	line_idx_t line_q;
	logic [BEAT_W-1:0] beat_q;
	logic [BEAT_W-1:0] last_beat_q;

	assign ar_ready = !arq_full;
	// one request in service at a time
	assign arq_pop = (state == RD_IDLE) && !arq_empty;

	sync_fifo #(
		.T(ar_req_t),
		.DEPTH(AR_FIFO_DEPTH)
	) u_ar_fifo (
		.clk(clk),
		.rst(rst),
		.push(ar_valid && ar_ready),
		.push_data(ar),
		.pop(arq_pop),
		.pop_data(arq_head),
		.empty(arq_empty),
		.full(arq_full)
	);

	// one store read per beat
	assign st_rd_en = (state == RD_ISSUE);
	assign st_rd = '{line: line_q, beat: beat_q};

	always_ff @(posedge clk) begin
		if (arq_pop) begin
			id_q <= arq_head.id;
			line_q <= arq_head.addr[LINE_OFS +: LINE_IDX_W];
			last_beat_q <= arq_head.len[BEAT_W-1:0];
		end
	end

	// beat fsm, r held until accepted
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= RD_IDLE;
			beat_q <= '0;
			r_valid <= 1'b0;
			r <= '0;
		end else begin
			case (state)
				RD_IDLE: begin
					if (arq_pop) begin
						state <= RD_ISSUE;
						beat_q <= '0;
					end
				end
				RD_ISSUE: state <= RD_WAIT;
				RD_WAIT: begin
					// store answers one cycle after the issue
					if (st_rd_valid) begin
						r_valid <= 1'b1;
						r <= '{id: id_q, data: st_rd_data, last: (beat_q == last_beat_q)};
						state <= RD_HOLD;
					end
				end
				RD_HOLD: begin
					if (r_ready) begin
						r_valid <= 1'b0;
						// next beat or next request
						if (r.last) begin
							state <= RD_IDLE;
						end else begin
							beat_q <= beat_q + 1'b1;
							state <= RD_ISSUE;
						end
					end
				end
				default: state <= RD_IDLE;
			endcase
		end
	end

endmodule

// File: mem_wr_engine.sv
`timescale 1ns/1ps

// aw and w handling, ordered b responses
module mem_wr_engine
	import mem_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic aw_valid,
	input aw_req_t aw,
	output logic aw_ready,
	input logic w_valid,
	input w_beat_t w,
	output logic w_ready,
	output logic b_valid,
	output b_resp_t b,
	input logic b_ready,
	output logic st_wr_en,
	output store_wr_t st_wr
);

	typedef enum logic {
		WR_IDLE,
		WR_DATA
	} wr_state_e;

	wr_state_e state;
	// captured burst context
	id_t id_q;
	line_idx_t line_q;
	logic [BEAT_W-1:0] beat_q;
	logic [BEAT_W-1:0] last_beat_q;

	logic aw_fire;
	logic w_fire;
	logic burst_done;

	// b id queue
	logic bq_pop;
	logic bq_empty;
	logic bq_full;
	id_t bq_head;

	// no new burst while the id queue has no room
	assign aw_ready = (state == WR_IDLE) && !bq_full;
	assign w_ready = (state == WR_DATA);
	assign aw_fire = aw_valid && aw_ready;
	assign w_fire = w_valid && w_ready;
	assign burst_done = w_fire && (beat_q == last_beat_q);

	// every accepted beat goes straight to the store
	assign st_wr_en = w_fire;
	assign st_wr = '{line: line_q, beat: beat_q, data: w.data, strb: w.strb};

	// idle/data fsm and beat counter
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= WR_IDLE;
			beat_q <= '0;
		end else begin
			case (state)
				WR_IDLE: begin
					if (aw_fire) begin
						state <= WR_DATA;
						beat_q <= '0;
					end
				end
				WR_DATA: begin
					if (burst_done) begin
						state <= WR_IDLE;
					end else if (w_fire) begin
						beat_q <= beat_q + 1'b1;
					end
				end
				default: state <= WR_IDLE;
			endcase
		end
	end

	// address phase capture
	// only the low len bit counts, longer bursts are unsupported
	always_ff @(posedge clk) begin
		if (aw_fire) begin
			id_q <= aw.id;
			line_q <= aw.addr[LINE_OFS +: LINE_IDX_W];
			last_beat_q <= aw.len[BEAT_W-1:0];
		end
	end

	// ids queued in aw order once the last beat lands
	sync_fifo #(
		.T(id_t),
		.DEPTH(B_FIFO_DEPTH)
	) u_b_fifo (
		.clk(clk),
		.rst(rst),
		.push(burst_done),
		.push_data(id_q),
		.pop(bq_pop),
		.pop_data(bq_head),
		.empty(bq_empty),
		.full(bq_full)
	);

	// refill the response register when empty or draining
	assign bq_pop = !bq_empty && (!b_valid || b_ready);

	always_ff @(posedge clk) begin
		if (rst) begin
			b_valid <= 1'b0;
			b <= '0;
		end else if (bq_pop) begin
			b_valid <= 1'b1;
			b.id <= bq_head;
		end else if (b_ready) begin
			b_valid <= 1'b0;
		end
	end

endmodule

// File: sync_fifo.sv
`timescale 1ns/1ps

// circular buffer queue, payload type chosen per instance
module sync_fifo
	import mem_pkg::*;
#(
	parameter type T = id_t,
	parameter int DEPTH = B_FIFO_DEPTH
) (
	input logic clk,
	input logic rst,
	input logic push,
	input T push_data,
	input logic pop,
	output T pop_data,
	output logic empty,
	output logic full
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	T slots [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic do_push;
	logic do_pop;

	// push on full and pop on empty are dropped
	assign do_push = push && !full;
	assign do_pop = pop && !empty;

	assign empty = (count == '0);
	assign full = (count == CNT_W'(DEPTH));
	// head entry always visible
	assign pop_data = slots[rd_ptr];

	// payload storage
	always_ff @(posedge clk) begin
		if (do_push) begin
			slots[wr_ptr] <= push_data;
		end
	end

	// pointers and occupancy
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			// simultaneous push and pop leaves count alone
			if (do_push && !do_pop) begin
				count <= count + 1'b1;
			end else if (do_pop && !do_push) begin
				count <= count - 1'b1;
			end
		end
	end

endmodule
